//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run the useless box testbench

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f sources.f \
  --top-module useless_box_tb -o useless_box_sim &&
./obj_dir/useless_box_sim | tee /dev/stderr | \
  grep -q "Simulation completed successfully" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

//--- sim/tb_clock.sv
// Testbench clock generator
// Free-running clock, low at time zero
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period_ns = 40
) (
  output logic clk
);

  initial clk = 1'b0;

  // Half period per phase
  always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- sim/useless_box_tb.sv
// Testbench for the useless box control core
// Steps the mode button, applies a table of inputs and checks relay,
// servo and motor outputs against expected values
`timescale 1ns/1ps
`default_nettype none

`include "box_cfg.svh"

module useless_box_tb;

  localparam int drive_dly     = 2;
  localparam int press_cycles  = `BOX_DEB_DEPTH + 2;
  localparam int settle_cycles = `BOX_DEB_DEPTH + 3;
  localparam int num_fixed     = 26;
  localparam int num_random    = 8;
  localparam int num_entries   = num_fixed + num_random;
  // Reset plus a worst-case budget per table entry
  localparam int cycle_limit   = 16 + num_entries * 60;

  localparam logic [1:0] m_ns  = box_mode_pkg::NS;
  localparam logic [1:0] m_ub  = box_mode_pkg::UB;
  localparam logic [1:0] m_uc  = box_mode_pkg::UC;
  localparam logic [2:0] w_cl  = box_mode_pkg::CLASSIC;
  localparam logic [2:0] w_dg  = box_mode_pkg::DODGE;
  localparam logic [2:0] w_ad  = box_mode_pkg::ADVANCE;
  localparam logic [2:0] w_bad = 3'b000;

  // One stimulus vector with its expected outputs
  // cmds is {forward, backward, left, right}
  typedef struct packed {
    logic [1:0]             mode;
    logic [2:0]             wanted;
    logic                   sw0;
    logic [3:0]             ir;
    logic [`BOX_DIST_W-1:0] d0;
    logic [`BOX_DIST_W-1:0] d1;
    logic                   ble;
    logic [3:0]             cmds;
    logic                   pulse;
    logic                   relay;
    logic                   en;
    logic                   sel;
    logic [4:0]             amt;
    logic [1:0]             cw;
    logic [1:0]             ccw;
  } entry_t;

  logic                   clk;
  logic                   rst;
  logic                   mode_sw;
  logic [2:0]             wanted_ub;
  logic                   sw0;
  logic [3:0]             ir_sensor;
  logic [`BOX_DIST_W-1:0] dist_0;
  logic [`BOX_DIST_W-1:0] dist_1;
  logic                   ble_err;
  logic                   cmd_switch;
  logic                   cmd_forward;
  logic                   cmd_backward;
  logic                   cmd_left;
  logic                   cmd_right;
  logic [1:0]             mode;
  logic                   relay;
  logic                   servo_enable;
  logic                   servo_sel;
  logic [4:0]             servo_amount;
  logic [1:0]             motor_cw;
  logic [1:0]             motor_ccw;

  entry_t vectors[$];
  int     seed;
  int     cycles = 0;

  tb_clock #(.period_ns(40)) clk_gen (.clk(clk));

  useless_box_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .mode_sw      (mode_sw),
    .wanted_ub    (wanted_ub),
    .sw0          (sw0),
    .ir_sensor    (ir_sensor),
    .dist_0       (dist_0),
    .dist_1       (dist_1),
    .ble_err      (ble_err),
    .cmd_switch   (cmd_switch),
    .cmd_forward  (cmd_forward),
    .cmd_backward (cmd_backward),
    .cmd_left     (cmd_left),
    .cmd_right    (cmd_right),
    .mode         (mode),
    .relay        (relay),
    .servo_enable (servo_enable),
    .servo_sel    (servo_sel),
    .servo_amount (servo_amount),
    .motor_cw     (motor_cw),
    .motor_ccw    (motor_ccw)
  );

  // Watchdog on total run length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  // Drive point sits just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #drive_dly;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %0d ns %s expected %0h actual %0h", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic add_entry(input logic [1:0] m, input logic [2:0] w, input logic s,
                           input logic [3:0] ir, input int d0, input int d1,
                           input logic ble, input logic [3:0] cmds, input logic pulse,
                           input logic relay_x, input logic en_x, input logic sel_x,
                           input int amt_x, input logic [1:0] cw_x, input logic [1:0] ccw_x);
    entry_t e;
    e.mode   = m;
    e.wanted = w;
    e.sw0    = s;
    e.ir     = ir;
    e.d0     = d0[`BOX_DIST_W-1:0];
    e.d1     = d1[`BOX_DIST_W-1:0];
    e.ble    = ble;
    e.cmds   = cmds;
    e.pulse  = pulse;
    e.relay  = relay_x;
    e.en     = en_x;
    e.sel    = sel_x;
    e.amt    = amt_x[4:0];
    e.cw     = cw_x;
    e.ccw    = ccw_x;
    vectors.push_back(e);
  endtask

  // Hand-worked vectors, target starts at 0
  task automatic build_fixed_entries();
    // mode  want  sw ir     d0   d1  ble cmds     pls  rly en sel amt cw     ccw
    add_entry(m_ns, w_cl, 0, 4'hF, 100, 100, 0, 4'b0000, 0,  0, 0, 0,  0, 2'b00, 2'b00);
    add_entry(m_ns, w_cl, 1, 4'hF, 100, 100, 0, 4'b0000, 0,  1, 1, 0, 31, 2'b00, 2'b00);
    // Target toggles to 1
    add_entry(m_ns, w_cl, 0, 4'hF, 100, 100, 0, 4'b0000, 1,  0, 1, 1, 31, 2'b00, 2'b00);
    // Broken link, target stays 1
    add_entry(m_ns, w_cl, 1, 4'hF, 100, 100, 1, 4'b0000, 1,  1, 0, 1,  0, 2'b00, 2'b00);
    // Target back to 0
    add_entry(m_ns, w_cl, 1, 4'hF, 100, 100, 0, 4'b0000, 1,  1, 1, 0, 31, 2'b00, 2'b00);
    add_entry(m_ub, w_cl, 0, 4'hF, 100, 100, 0, 4'b0000, 0,  0, 1, 0,  0, 2'b00, 2'b00);
    add_entry(m_ub, w_cl, 1, 4'hF, 100, 100, 0, 4'b0000, 0,  0, 1, 0, 31, 2'b00, 2'b00);
    // Dodge under mismatch does not flip
    add_entry(m_ub, w_dg, 1, 4'hF, 100, 100, 0, 4'b0000, 0,  0, 1, 1,  0, 2'b00, 2'b00);
    add_entry(m_ub, w_dg, 0, 4'hF,   9,   3, 0, 4'b0000, 0,  0, 1, 0,  0, 2'b00, 2'b11);
    add_entry(m_ub, w_dg, 0, 4'hF,   7,   5, 0, 4'b0000, 0,  0, 1, 0,  0, 2'b11, 2'b00);
    add_entry(m_ub, w_dg, 0, 4'hF,   3,   5, 0, 4'b0000, 0,  0, 1, 0,  0, 2'b00, 2'b00);
    add_entry(m_ub, w_bad, 0, 4'hF, 100, 100, 0, 4'b0000, 0, 0, 1, 0,  0, 2'b00, 2'b00);
    // Closer effect
    add_entry(m_ub, w_ad, 0, 4'hF,   5,  30, 0, 4'b0000, 0,  0, 1, 1, 15, 2'b00, 2'b00);
    add_entry(m_ub, w_ad, 0, 4'hF, 100, 100, 0, 4'b0000, 0,  0, 1, 1,  0, 2'b00, 2'b00);
    add_entry(m_ub, w_ad, 0, 4'hB, 100, 100, 0, 4'b0000, 0,  0, 1, 1, 31, 2'b00, 2'b00);
    add_entry(m_ub, w_ad, 0, 4'hF,   8,  30, 0, 4'b0000, 0,  0, 1, 1, 24, 2'b00, 2'b00);
    add_entry(m_ub, w_ad, 0, 4'hF,  40,   5, 0, 4'b0000, 0,  0, 1, 1, 31, 2'b00, 2'b00);
    add_entry(m_ub, w_ad, 1, 4'hF, 100, 100, 0, 4'b0000, 0,  0, 1, 0, 31, 2'b00, 2'b00);
    // Remote drive
    add_entry(m_uc, w_cl, 0, 4'hF, 100, 100, 0, 4'b1000, 0,  0, 0, 0,  0, 2'b11, 2'b00);
    add_entry(m_uc, w_cl, 0, 4'hF, 100, 100, 0, 4'b0100, 0,  0, 0, 0,  0, 2'b00, 2'b11);
    add_entry(m_uc, w_cl, 0, 4'hF, 100, 100, 0, 4'b0010, 0,  0, 0, 0,  0, 2'b10, 2'b00);
    add_entry(m_uc, w_cl, 0, 4'hF, 100, 100, 0, 4'b0001, 0,  0, 0, 0,  0, 2'b01, 2'b00);
    add_entry(m_uc, w_cl, 0, 4'hF, 100, 100, 0, 4'b0000, 0,  0, 0, 0,  0, 2'b00, 2'b00);
    add_entry(m_uc, w_cl, 0, 4'hF, 100, 100, 1, 4'b1010, 0,  0, 0, 0,  0, 2'b00, 2'b00);
    add_entry(m_uc, w_cl, 1, 4'hF, 100, 100, 0, 4'b0011, 0,  0, 1, 1,  0, 2'b10, 2'b00);
    // Wrap back to NS
    add_entry(m_ns, w_cl, 0, 4'hF, 100, 100, 0, 4'b0000, 0,  0, 0, 0,  0, 2'b00, 2'b00);
  endtask

  // Expected {cw, ccw} for remote drive by command priority
  function automatic logic [3:0] uc_motor_lines(input logic ble, input logic [3:0] cmds);
    logic [1:0] cw;
    logic [1:0] ccw;
    cw  = 2'b00;
    ccw = 2'b00;
    if (!ble) begin
      if (cmds[3]) begin
        cw = 2'b11;
      end else if (cmds[2]) begin
        ccw = 2'b11;
      end else if (cmds[1]) begin
        cw = 2'b10;
      end else if (cmds[0]) begin
        cw = 2'b01;
      end
    end
    return {cw, ccw};
  endfunction

  // Button order is NS, UB, UC and back to NS
  function automatic logic [1:0] following_mode(input logic [1:0] m);
    if (m === m_ns) begin
      return m_ub;
    end else if (m === m_ub) begin
      return m_uc;
    end else begin
      return m_ns;
    end
  endfunction

  // Random command mixes in UC with the switch on target
  task automatic build_random_entries();
    int         r;
    logic       ble;
    logic [3:0] lines;
    for (int i = 0; i < num_random; i++) begin
      r     = $random(seed);
      ble   = r[6] & r[5];
      lines = uc_motor_lines(ble, r[3:0]);
      add_entry(m_uc, w_cl, 0, 4'hF, 100, 100, ble, r[3:0], 0, 0, 0, 0, 0,
                lines[3:2], lines[1:0]);
    end
  endtask

  task automatic press_mode_button();
    mode_sw = 1'b1;
    repeat (press_cycles) next_cycle();
    mode_sw = 1'b0;
    repeat (press_cycles) next_cycle();
  endtask

  // Press until the wanted mode shows, at most three times
  // Each press must move exactly one step along the mode cycle
  task automatic select_mode(input logic [1:0] target);
    int         presses;
    logic [1:0] expected;
    presses = 0;
    while (mode !== target) begin
      if (presses >= 3) begin
        $display("Mode %0d was not reached after three button presses", target);
        $display("Simulation failed");
        $fatal(1, "mode stepping stuck");
      end else begin
        expected = following_mode(mode);
        press_mode_button();
        check_value("mode after press", expected, mode);
        presses++;
      end
    end
  endtask

  task automatic apply_entry(input entry_t e);
    wanted_ub    = e.wanted;
    sw0          = e.sw0;
    ir_sensor    = e.ir;
    dist_0       = e.d0;
    dist_1       = e.d1;
    ble_err      = e.ble;
    cmd_forward  = e.cmds[3];
    cmd_backward = e.cmds[2];
    cmd_left     = e.cmds[1];
    cmd_right    = e.cmds[0];
    if (e.pulse) begin
      next_cycle();
      cmd_switch = 1'b1;
      repeat (2) next_cycle();
      cmd_switch = 1'b0;
    end
    // Room for the IR debouncer to settle
    repeat (settle_cycles) next_cycle();
  endtask

  task automatic check_entry(input int idx, input entry_t e);
    check_value($sformatf("entry %0d mode", idx), e.mode, mode);
    check_value($sformatf("entry %0d relay", idx), e.relay, relay);
    check_value($sformatf("entry %0d servo_enable", idx), e.en, servo_enable);
    check_value($sformatf("entry %0d servo_sel", idx), e.sel, servo_sel);
    check_value($sformatf("entry %0d servo_amount", idx), e.amt, servo_amount);
    check_value($sformatf("entry %0d motor_cw", idx), e.cw, motor_cw);
    check_value($sformatf("entry %0d motor_ccw", idx), e.ccw, motor_ccw);
  endtask

  initial begin
    rst          = 1'b1;
    mode_sw      = 1'b0;
    wanted_ub    = w_cl;
    sw0          = 1'b0;
    ir_sensor    = 4'hF;
    dist_0       = 100;
    dist_1       = 100;
    ble_err      = 1'b0;
    cmd_switch   = 1'b0;
    cmd_forward  = 1'b0;
    cmd_backward = 1'b0;
    cmd_left     = 1'b0;
    cmd_right    = 1'b0;
    seed         = 21355;
    build_fixed_entries();
    build_random_entries();
    check_value("vector_count", num_entries, vectors.size());
    repeat (16) @(posedge clk);
    #drive_dly;
    rst = 1'b0;
    next_cycle();
    // Box wakes up as a plain switch
    check_value("mode after reset", m_ns, mode);
    for (int i = 0; i < vectors.size(); i++) begin
      select_mode(vectors[i].mode);
      apply_entry(vectors[i]);
      check_entry(i, vectors[i]);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/box_mode_pkg.sv
src/actuator_pkg.sv
src/debounce.sv
src/mode_sequencer.sv
src/servo_planner.sv
src/motor_planner.sv
src/useless_box_top.sv
sim/tb_clock.sv
sim/useless_box_tb.sv

//--- src/actuator_pkg.sv
// Actuator types for the useless box
// Sensor distances and the servo lift amount
`default_nettype none

`include "box_cfg.svh"

package actuator_pkg;

  // Raw ultrasonic distance
  typedef logic [`BOX_DIST_W-1:0] dist_t;

  // One extra bit so the right-side offset never wraps
  typedef logic [`BOX_DIST_W:0] dist_ext_t;

  // Servo lift amount
  // 0 is rest and 31 is full lift
  typedef logic [4:0] servo_amt_t;

endpackage

`default_nettype wire

//--- src/box_cfg.svh
// Useless box configuration constants
// Debounce depth, distance width and the servo and motor thresholds
`ifndef BOX_CFG_SVH
`define BOX_CFG_SVH

// Consecutive high samples before a debounced line rises
`define BOX_DEB_DEPTH 4

// Width of one ultrasonic distance reading
`define BOX_DIST_W 20

// Beyond this distance nobody is near the box
`define BOX_GOOD_DIST 20

// Added to the right-side reading since the box is not symmetric
`define BOX_DIST_DELTA 4

// Servo amount for a full lift of the arm
`define BOX_FULL_LIFT 31

// Scaled distance where the lift saturates
`define BOX_LIFT_CAP 25

`endif

//--- src/box_mode_pkg.sv
// Mode types for the useless box
// Operating mode stepped by the button and the wanted useless-box behaviour
`default_nettype none

package box_mode_pkg;

  // Operating mode of the box
  // Code 01 is never entered
  typedef enum logic [1:0] {
    NS = 2'b00,
    UB = 2'b10,
    UC = 2'b11
  } mode_t;

  // Wanted behaviour in UB, one-hot
  // Any other code counts as invalid
  typedef enum logic [2:0] {
    CLASSIC = 3'b001,
    DODGE   = 3'b010,
    ADVANCE = 3'b100
  } ub_sel_t;

endpackage

`default_nettype wire

//--- src/debounce.sv
// Multi-bit debouncer
// Each output bit rises after BOX_DEB_DEPTH high samples in a row
// and falls right after a single low sample
`timescale 1ns/1ps
`default_nettype none

`include "box_cfg.svh"

module debounce #(
  parameter int WIDTH = 1
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic [WIDTH-1:0] raw,
  output logic      [WIDTH-1:0] clean
);

  // Older samples per bit
  // The live sample completes the window
  localparam int hist_w = `BOX_DEB_DEPTH - 1;

  logic [WIDTH-1:0][hist_w-1:0] hist;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hist  <= '0;
      clean <= '0;
    end else begin
      for (int i = 0; i < WIDTH; i++) begin
        // Shift in the newest sample
        hist[i]  <= {hist[i][hist_w-2:0], raw[i]};
        // High only when the whole window is high
        clean[i] <= &{hist[i], raw[i]};
      end
    end
  end

endmodule

`default_nettype wire

//--- src/mode_sequencer.sv
// Mode sequencer for the useless box
// Steps NS, UB, UC on each button press, tracks the target switch
// position and drives the relay
`timescale 1ns/1ps
`default_nettype none

module mode_sequencer (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           btn_clean,
  input  wire logic           sw0,
  input  wire logic           cmd_switch,
  input  wire logic           ble_err,
  output box_mode_pkg::mode_t mode,
  output logic                sw_target,
  output logic                relay
);

  logic                btn_prev;
  logic                cmd_prev;
  logic                btn_rise;
  logic                cmd_rise;
  box_mode_pkg::mode_t mode_next;

  // One step per press
  assign btn_rise = btn_clean & ~btn_prev;
  // Remote toggle acts on the rising edge only
  assign cmd_rise = cmd_switch & ~cmd_prev;

  // Mode cycle
  always_comb begin
    case (mode)
      box_mode_pkg::NS: mode_next = box_mode_pkg::UB;
      box_mode_pkg::UB: mode_next = box_mode_pkg::UC;
      default:          mode_next = box_mode_pkg::NS;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      btn_prev  <= 1'b0;
      cmd_prev  <= 1'b0;
      mode      <= box_mode_pkg::NS;
      sw_target <= 1'b0;
    end else begin
      btn_prev <= btn_clean;
      cmd_prev <= cmd_switch;
      if (btn_rise) begin
        mode <= mode_next;
      end
      // Target only moves in NS with a clean link
      if (cmd_rise && !ble_err && (mode == box_mode_pkg::NS)) begin
        sw_target <= ~sw_target;
      end
    end
  end

  // Relay follows the user switch in NS
  assign relay = (mode == box_mode_pkg::NS) ? sw0 : 1'b0;

endmodule

`default_nettype wire

//--- src/motor_planner.sv
// Motor planner for the useless box
// Dodge decisions in UB and remote drive in UC, mapped onto the
// cw and ccw lines of the left and right motors
`timescale 1ns/1ps
`default_nettype none

`include "box_cfg.svh"

module motor_planner (
  input  wire box_mode_pkg::mode_t   mode,
  input  wire box_mode_pkg::ub_sel_t wanted_ub,
  input  wire actuator_pkg::dist_t   dist_0,
  input  wire actuator_pkg::dist_t   dist_1,
  input  wire logic                  ble_err,
  input  wire logic                  cmd_forward,
  input  wire logic                  cmd_backward,
  input  wire logic                  cmd_left,
  input  wire logic                  cmd_right,
  output logic [1:0]                 motor_cw,
  output logic [1:0]                 motor_ccw
);

  actuator_pkg::dist_ext_t d0_ext;
  actuator_pkg::dist_ext_t d1_off;
  logic                    dodge_stop;
  // Index 0 is left and index 1 is right
  logic [1:0]              run;
  logic [1:0]              dir;

  assign d0_ext = {1'b0, dist_0};
  assign d1_off = {1'b0, dist_1} + actuator_pkg::dist_ext_t'(`BOX_DIST_DELTA);

  // Stop when pressed against something or when nobody is around
  // Near limit is a third of the good distance, far limit a half
  assign dodge_stop = (d0_ext < (`BOX_GOOD_DIST / 3 + 1)) ||
                      (d1_off < (`BOX_GOOD_DIST / 3 + 1)) ||
                      ((d0_ext > (`BOX_GOOD_DIST / 2)) &&
                       (d1_off > (`BOX_GOOD_DIST / 2)));

  always_comb begin
    run = 2'b00;
    dir = 2'b00;
    case (mode)
      box_mode_pkg::UB: begin
        if ((wanted_ub == box_mode_pkg::DODGE) && !dodge_stop) begin
          run = 2'b11;
          // User closer on the right, back off the other way
          dir = (d0_ext > d1_off) ? 2'b00 : 2'b11;
        end
      end
      box_mode_pkg::UC: begin
        // Commands ignored on a broken link
        if (!ble_err) begin
          if (cmd_forward) begin
            run = 2'b11;
            dir = 2'b11;
          end else if (cmd_backward) begin
            run = 2'b11;
            dir = 2'b00;
          end else if (cmd_left) begin
            // Right wheel only
            run = 2'b10;
            dir = 2'b10;
          end else if (cmd_right) begin
            // Left wheel only
            run = 2'b01;
            dir = 2'b01;
          end
        end
      end
      default: begin
        run = 2'b00;
      end
    endcase
  end

  // Direction 1 turns cw, direction 0 turns ccw
  assign motor_cw  = run & dir;
  assign motor_ccw = run & ~dir;

endmodule

`default_nettype wire

//--- src/servo_planner.sv
// Servo planner for the useless box
// Picks enable, side and lift amount from the mode, the switch state
// and the IR and ultrasonic sensors
`timescale 1ns/1ps
`default_nettype none

`include "box_cfg.svh"

module servo_planner (
  input  wire logic                  [3:0] ir_near,
  input  wire box_mode_pkg::mode_t         mode,
  input  wire box_mode_pkg::ub_sel_t       wanted_ub,
  input  wire logic                        sw0,
  input  wire logic                        sw_target,
  input  wire actuator_pkg::dist_t         dist_0,
  input  wire actuator_pkg::dist_t         dist_1,
  output logic                             servo_enable,
  output logic                             servo_sel,
  output actuator_pkg::servo_amt_t         servo_amount
);

  actuator_pkg::dist_ext_t  d0_ext;
  actuator_pkg::dist_ext_t  d1_off;
  actuator_pkg::dist_ext_t  near;
  logic [`BOX_DIST_W+2:0]   near_x3;
  logic                     any_ir;
  logic                     both_far;
  actuator_pkg::servo_amt_t closer_amt;

  // Right reading pushed out to match the left side
  assign d0_ext = {1'b0, dist_0};
  assign d1_off = {1'b0, dist_1} + actuator_pkg::dist_ext_t'(`BOX_DIST_DELTA);

  // Nearer of the two sides
  assign near = (d0_ext > d1_off) ? d1_off : d0_ext;

  // Three times the distance, wide enough to never wrap
  assign near_x3 = ({2'b00, near} << 1) + {2'b00, near};

  assign any_ir   = |ir_near;
  assign both_far = (d0_ext > `BOX_GOOD_DIST) && (d1_off > `BOX_GOOD_DIST);

  // Closer effect
  // The arm lifts higher as the user gets closer
  always_comb begin
    if (any_ir) begin
      // Hand right at the switch
      closer_amt = actuator_pkg::servo_amt_t'(`BOX_FULL_LIFT);
    end else if (both_far) begin
      closer_amt = '0;
    end else if (near_x3 < `BOX_LIFT_CAP) begin
      closer_amt = near_x3[4:0];
    end else begin
      closer_amt = actuator_pkg::servo_amt_t'(`BOX_FULL_LIFT);
    end
  end

  always_comb begin
    // Default is rest on the switch side
    servo_enable = 1'b1;
    servo_sel    = sw0;
    servo_amount = '0;
    if (sw0 == sw_target) begin
      if (mode != box_mode_pkg::UB) begin
        servo_enable = 1'b0;
      end else if (wanted_ub == box_mode_pkg::ADVANCE) begin
        // Tease from the other side
        servo_sel    = ~sw0;
        servo_amount = closer_amt;
      end
    end else begin
      // Switch moved away from target
      case (mode)
        box_mode_pkg::NS: begin
          servo_sel    = ~sw0;
          servo_amount = actuator_pkg::servo_amt_t'(`BOX_FULL_LIFT);
        end
        box_mode_pkg::UB: begin
          // Dodge runs away instead of flipping
          if ((wanted_ub == box_mode_pkg::CLASSIC) ||
              (wanted_ub == box_mode_pkg::ADVANCE)) begin
            servo_sel    = ~sw0;
            servo_amount = actuator_pkg::servo_amt_t'(`BOX_FULL_LIFT);
          end
        end
        default: begin
          servo_sel = sw0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/useless_box_top.sv
// Useless box control core
// Debounces the button and IR sensors and ties the mode sequencer
// to the servo and motor planners
`timescale 1ns/1ps
`default_nettype none

module useless_box_top (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      mode_sw,
  input  wire logic                [2:0] wanted_ub,
  input  wire logic                      sw0,
  input  wire logic                [3:0] ir_sensor,
  input  wire actuator_pkg::dist_t       dist_0,
  input  wire actuator_pkg::dist_t       dist_1,
  input  wire logic                      ble_err,
  input  wire logic                      cmd_switch,
  input  wire logic                      cmd_forward,
  input  wire logic                      cmd_backward,
  input  wire logic                      cmd_left,
  input  wire logic                      cmd_right,
  output logic                     [1:0] mode,
  output logic                           relay,
  output logic                           servo_enable,
  output logic                           servo_sel,
  output actuator_pkg::servo_amt_t       servo_amount,
  output logic                     [1:0] motor_cw,
  output logic                     [1:0] motor_ccw
);

  logic                  btn_clean;
  logic [3:0]            ir_near;
  logic                  sw_target;
  box_mode_pkg::mode_t   cur_mode;
  box_mode_pkg::ub_sel_t ub_sel;

  // Raw switch code, invalid codes pass through
  assign ub_sel = box_mode_pkg::ub_sel_t'(wanted_ub);
  assign mode   = cur_mode;

  debounce #(.WIDTH(1)) btn_deb (
    .clk   (clk),
    .rst   (rst),
    .raw   (mode_sw),
    .clean (btn_clean)
  );

  // IR lines pull low when something is in front
  debounce #(.WIDTH(4)) ir_deb (
    .clk   (clk),
    .rst   (rst),
    .raw   (~ir_sensor),
    .clean (ir_near)
  );

  mode_sequencer seq0 (
    .clk        (clk),
    .rst        (rst),
    .btn_clean  (btn_clean),
    .sw0        (sw0),
    .cmd_switch (cmd_switch),
    .ble_err    (ble_err),
    .mode       (cur_mode),
    .sw_target  (sw_target),
    .relay      (relay)
  );

  servo_planner servo0 (
    .ir_near      (ir_near),
    .mode         (cur_mode),
    .wanted_ub    (ub_sel),
    .sw0          (sw0),
    .sw_target    (sw_target),
    .dist_0       (dist_0),
    .dist_1       (dist_1),
    .servo_enable (servo_enable),
    .servo_sel    (servo_sel),
    .servo_amount (servo_amount)
  );

  motor_planner motor0 (
    .mode         (cur_mode),
    .wanted_ub    (ub_sel),
    .dist_0       (dist_0),
    .dist_1       (dist_1),
    .ble_err      (ble_err),
    .cmd_forward  (cmd_forward),
    .cmd_backward (cmd_backward),
    .cmd_left     (cmd_left),
    .cmd_right    (cmd_right),
    .motor_cw     (motor_cw),
    .motor_ccw    (motor_ccw)
  );

endmodule

`default_nettype wire
